// File: glitch_trigger.f
glitch_cfg_pkg.sv
glitch_fsm_pkg.sv
trigger_arm.sv
trigger_resync.sv
glitch_pulse_gen.sv
glitch_trigger_top.sv
tb_clock_gen.sv
glitch_trigger_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --timing --assert -Wno-fatal
TOP       := glitch_trigger_tb
FILELIST  := glitch_trigger.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: glitch_trigger_tb.sv
`timescale 1ns/1ps

module glitch_trigger_tb;

  logic clk;
  logic exttrig;
  logic trig_in;
  logic arm;
  logic single_mode;
  logic fsm_abort;
  logic easy_done_exit;
  logic [glitch_cfg_pkg::OFFSET_WIDTH-1:0]     offset;
  logic [glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] num_glitches;
  logic [glitch_cfg_pkg::PULSE_WIDTH_BITS-1:0] glitch_width;
  logic glitch_out;
  logic [glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] glitch_index;
  logic done;
  logic idle;
  glitch_fsm_pkg::resync_state_t fsm_state;

  int value_errors = 0;
  int other_errors = 0;
  int seed = 32'h441;
  int cycle = 0;             // counted on falling edges
  int done_seen = 0;
  int done_cycle = 0;        // cycle of the latest done pulse
  int busy_cycles = 0;       // cycles with idle low
  logic prev_out = 1'b0;
  int rise_cycle[$];         // cycle of each glitch_out rise
  logic [glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] rise_index[$];
  int rnd_ng[5];
  int rnd_off[5];
  int rnd_wid[5];
  event sampled;             // monitor has updated its records

  tb_clock_gen u_clk (.clk(clk), .exttrig(exttrig));

  glitch_trigger_top dut (
    .clk (clk), .exttrig (exttrig), .trig_in (trig_in), .arm (arm),
    .single_mode (single_mode), .fsm_abort (fsm_abort), .easy_done_exit (easy_done_exit),
    .offset (offset), .num_glitches (num_glitches), .glitch_width (glitch_width),
    .glitch_out (glitch_out), .glitch_index (glitch_index), .done (done), .idle (idle),
    .fsm_state (fsm_state)
  );

  // outputs sampled mid cycle while inputs move on the rising edge
  always @(negedge clk) begin
    cycle++;
    if (glitch_out && !prev_out) begin
      rise_cycle.push_back(cycle);
      rise_index.push_back(glitch_index);   // index seen at the rise
    end
    if (done) begin
      done_seen++;
      done_cycle = cycle;
    end
    if (!idle) busy_cycles++;
    prev_out = glitch_out;
    -> sampled;
  end

  task automatic check_state(input glitch_fsm_pkg::resync_state_t got,
                             input glitch_fsm_pkg::resync_state_t exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: %s expected %s got %s", $time, what, exp.name(), got.name());
    end
  endtask

  task automatic check_index(input logic [glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] got,
                             input logic [glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] exp,
                             input string what);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      value_errors++;
      $display("[ERROR] %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  // cycles one run may take from trigger to done plus slack
  function automatic int run_budget(input int ng, input int off);
    return (ng + 1) * (off + 2) + 64;
  endfunction

  task automatic watchdog(input int budget);
    repeat (budget) @(posedge clk);
    $display("watchdog: the run timed out after %0d cycles", budget);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic clear_record();
    rise_cycle.delete();
    rise_index.delete();
    done_seen = 0;
    busy_cycles = 0;
  endtask

  task automatic apply_config(input int ng, input int off, input int wid,
                              input logic single, input logic easy);
    @(posedge clk);
    num_glitches   <= ng[glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0];
    offset         <= off;
    glitch_width   <= wid[glitch_cfg_pkg::PULSE_WIDTH_BITS-1:0];
    single_mode    <= single;
    easy_done_exit <= easy;
  endtask

  task automatic pulse_trigger(input int hold);
    @(posedge clk);
    trig_in <= 1'b1;
    repeat (hold) @(posedge clk);
    trig_in <= 1'b0;
  endtask

  task automatic strobe_arm();
    @(posedge clk);
    arm <= 1'b1;
    @(posedge clk);
    arm <= 1'b0;
  endtask

  task automatic wait_for_done(input int limit, input string what);
    int n;
    n = 0;
    while (done_seen == 0 && n < limit) begin
      @(sampled);
      n++;
    end
    if (done_seen == 0) begin
      other_errors++;
      $display("timeout: %s saw no done pulse within %0d cycles", what, limit);
    end
  endtask

  task automatic wait_for_rises(input int count, input int limit, input string what);
    int n;
    n = 0;
    while (rise_cycle.size() < count && n < limit) begin
      @(sampled);
      n++;
    end
    if (rise_cycle.size() < count) begin
      other_errors++;
      $display("timeout: %s saw only %0d glitch pulses", what, rise_cycle.size());
    end
  endtask

  // one pulse per glitch offset+2 apart with index counting from 1
  task automatic check_train(input int ng, input int off, input string what);
    int k;
    logic [glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] exp_idx;
    check_count(rise_cycle.size(), ng + 1, {what, " pulse count"});
    for (k = 0; k < rise_cycle.size(); k++) begin
      exp_idx = k[glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] + 1'b1;
      check_index(rise_index[k], exp_idx, {what, " glitch_index at rise"});
      if (k > 0) check_count(rise_cycle[k] - rise_cycle[k-1], off + 2, {what, " spacing"});
    end
    check_count(done_seen, 1, {what, " done pulses"});
  endtask

  task automatic run_train(input int ng, input int off, input int wid,
                           input logic single, input logic easy, input string what);
    clear_record();
    apply_config(ng, off, wid, single, easy);
    pulse_trigger(2);
    wait_for_done((ng + 1) * (off + 2) + 40, what);
    repeat (wid + 8) @(sampled);          // last pulse may outlast done
    check_train(ng, off, what);
    check_state(fsm_state, glitch_fsm_pkg::RS_IDLE, {what, " final state"});
    check_count(int'(idle), 1, {what, " idle"});
  endtask

  // trigger that must not start anything
  task automatic expect_no_run(input string what);
    clear_record();
    pulse_trigger(2);
    repeat (40) @(sampled);
    check_count(rise_cycle.size(), 0, {what, " pulse count"});
    check_count(done_seen, 0, {what, " done pulses"});
    check_count(busy_cycles, 0, {what, " cycles out of idle"});
  endtask

  task automatic test_abort_held_trigger();
    clear_record();
    apply_config(1, 4, 2, 1'b0, 1'b0);
    @(posedge clk);
    trig_in <= 1'b1;                      // held through the train
    wait_for_rises(2, 2 * 6 + 20, "held trigger");
    repeat (20) @(sampled);
    check_state(fsm_state, glitch_fsm_pkg::RS_DONE, "held trigger state");
    check_count(done_seen, 0, "held trigger done pulses");
    @(posedge clk);
    trig_in <= 1'b0;                      // sync still high for two more edges
    @(posedge clk);
    fsm_abort <= 1'b1;
    @(posedge clk);
    fsm_abort <= 1'b0;
    @(sampled);
    check_count(int'(done), 1, "done after abort");
    check_state(fsm_state, glitch_fsm_pkg::RS_IDLE, "state after abort");
    repeat (20) @(sampled);
    check_count(done_seen, 1, "abort done pulses");
    check_count(rise_cycle.size(), 2, "abort pulse count");
    check_state(fsm_state, glitch_fsm_pkg::RS_IDLE, "abort final state");
  endtask

  initial begin
    int budget;
    int k;
    trig_in        = 1'b0;
    arm            = 1'b0;
    single_mode    = 1'b0;
    fsm_abort      = 1'b0;
    easy_done_exit = 1'b0;
    offset         = '0;
    num_glitches   = '0;
    glitch_width   = '0;
    for (k = 0; k < 5; k++) begin
      rnd_off[k] = 1 + ({$random(seed)} % 20);
      rnd_ng[k]  = {$random(seed)} % 8;
      rnd_wid[k] = 1 + ({$random(seed)} % (rnd_off[k] + 1));   // keeps width <= offset+1
    end
    budget = 16 + run_budget(2, 5) + run_budget(1, 4) + 2 * run_budget(1, 6)
           + run_budget(0, 3) + run_budget(1, 4);
    for (k = 0; k < 5; k++) begin
      budget += run_budget(rnd_ng[k], rnd_off[k]);
    end
    fork
      watchdog(budget);
    join_none
    wait (exttrig == 1'b0);
    @(sampled);
    check_count(int'(glitch_out), 0, "glitch_out after reset");
    check_count(int'(done), 0, "done after reset");
    check_count(int'(idle), 1, "idle after reset");
    check_state(fsm_state, glitch_fsm_pkg::RS_IDLE, "state after reset");

    run_train(2, 5, 2, 1'b0, 1'b0, "continuous");
    apply_config(1, 4, 2, 1'b1, 1'b0);
    expect_no_run("single mode unarmed");
    strobe_arm();
    run_train(1, 6, 3, 1'b1, 1'b0, "single mode armed");
    expect_no_run("single mode after done");
    run_train(0, 3, 3, 1'b0, 1'b1, "easy done exit");
    // exit needs no completed pulse so done lands with the rise
    if (rise_cycle.size() == 1) begin
      check_count(done_cycle - rise_cycle[0], 0, "easy done exit done cycle");
    end
    test_abort_held_trigger();
    for (k = 0; k < 5; k++) begin
      run_train(rnd_ng[k], rnd_off[k], rnd_wid[k], 1'b0, 1'b0, "random run");
    end

    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic exttrig    // reset, high for the first 3 cycles
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  initial begin
    exttrig = 1'b1;
    repeat (3) @(posedge clk);
    exttrig <= 1'b0;         // released on a rising edge
  end

endmodule

// File: glitch_trigger_top.sv
`timescale 1ns/1ps

module glitch_trigger_top (
  input  logic clk,
  input  logic exttrig,            // async reset
  input  logic trig_in,
  input  logic arm,
  input  logic single_mode,
  input  logic fsm_abort,
  input  logic easy_done_exit,
  input  logic [glitch_cfg_pkg::OFFSET_WIDTH-1:0]     offset,
  input  logic [glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] num_glitches,
  input  logic [glitch_cfg_pkg::PULSE_WIDTH_BITS-1:0] glitch_width,
  output logic glitch_out,
  output logic [glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] glitch_index,
  output logic done,
  output logic idle,
  output glitch_fsm_pkg::resync_state_t fsm_state
);

  logic trig_sync;
  logic armed;
  logic glitch_fire;
  logic [glitch_cfg_pkg::DONE_COUNT_WIDTH-1:0] done_count;  // pulse gen back to resync

  trigger_arm u_arm (
    .clk       (clk),
    .exttrig   (exttrig),
    .trig_in   (trig_in),
    .arm       (arm),
    .done      (done),        // clears armed after a run
    .trig_sync (trig_sync),
    .armed     (armed)
  );

  trigger_resync u_resync (
    .clk            (clk),
    .exttrig        (exttrig),
    .trig_sync      (trig_sync),
    .armed          (armed),
    .single_mode    (single_mode),
    .fsm_abort      (fsm_abort),
    .easy_done_exit (easy_done_exit),
    .offset         (offset),
    .num_glitches   (num_glitches),
    .done_count     (done_count),
    .glitch_fire    (glitch_fire),
    .index          (glitch_index),
    .done           (done),
    .idle           (idle),
    .fsm_state      (fsm_state)
  );

  glitch_pulse_gen u_pulse (
    .clk          (clk),
    .exttrig      (exttrig),
    .glitch_fire  (glitch_fire),
    .glitch_width (glitch_width),
    .idle         (idle),
    .glitch_out   (glitch_out),
    .done_count   (done_count)
  );

endmodule

// File: glitch_pulse_gen.sv
`timescale 1ns/1ps

module glitch_pulse_gen (
  input  logic clk,
  input  logic exttrig,
  input  logic glitch_fire,   // one cycle request from resync
  input  logic [glitch_cfg_pkg::PULSE_WIDTH_BITS-1:0] glitch_width,
  input  logic idle,          // resync FSM idle, clears the count
  output logic glitch_out,
  output logic [glitch_cfg_pkg::DONE_COUNT_WIDTH-1:0] done_count
);

  glitch_fsm_pkg::pulse_state_t pg_state;

  logic [glitch_cfg_pkg::PULSE_WIDTH_BITS-1:0] width_cnt;   // cycles left minus one
  logic [glitch_cfg_pkg::PULSE_WIDTH_BITS-1:0] width_m1;
  logic pulse_end;

  // width 0 behaves as 1
  assign width_m1  = (glitch_width == '0) ? '0 : glitch_width - 1'b1;
  assign pulse_end = (pg_state == glitch_fsm_pkg::PG_HIGH) && (width_cnt == '0);

  // pulse is the state itself, rises the cycle after fire
  assign glitch_out = (pg_state == glitch_fsm_pkg::PG_HIGH);

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      pg_state  <= glitch_fsm_pkg::PG_IDLE;
      width_cnt <= '0;
    end else begin
      case (pg_state)
        glitch_fsm_pkg::PG_IDLE: begin
          if (glitch_fire) begin
            pg_state  <= glitch_fsm_pkg::PG_HIGH;
            width_cnt <= width_m1;
          end
        end
        glitch_fsm_pkg::PG_HIGH: begin
          if (pulse_end) begin
            pg_state <= glitch_fsm_pkg::PG_IDLE;   // falling edge
          end else begin
            width_cnt <= width_cnt - 1'b1;
          end
        end
        default: pg_state <= glitch_fsm_pkg::PG_IDLE;
      endcase
    end
  end

  // finished pulses, read back through the resync count pipe
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      done_count <= '0;
    end else if (idle) begin
      done_count <= '0;           // fresh count every run
    end else if (pulse_end) begin
      done_count <= done_count + 1'b1;
    end
  end

  // holds only while glitch_width <= offset+1
  a_no_fire_while_high: assert property (
    @(posedge clk) disable iff (exttrig)
    glitch_fire |-> (pg_state == glitch_fsm_pkg::PG_IDLE)
  ) else $error("glitch_fire while pulse still high, width too long for offset");

endmodule

// File: trigger_resync.sv
`timescale 1ns/1ps

module trigger_resync (
  input  logic clk,
  input  logic exttrig,
  input  logic trig_sync,        // already in the clk domain
  input  logic armed,
  input  logic single_mode,      // 1 = needs armed to start
  input  logic fsm_abort,        // strobe that forces DONE to exit
  input  logic easy_done_exit,   // skip the count check for a single glitch
  input  logic [glitch_cfg_pkg::OFFSET_WIDTH-1:0]     offset,
  input  logic [glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] num_glitches,
  input  logic [glitch_cfg_pkg::DONE_COUNT_WIDTH-1:0] done_count,  // from pulse gen
  output logic glitch_fire,      // one cycle per glitch
  output logic [glitch_cfg_pkg::NUM_GLITCH_WIDTH-1:0] index,
  output logic done,
  output logic idle,
  output glitch_fsm_pkg::resync_state_t fsm_state
);

  glitch_fsm_pkg::resync_state_t state;

  logic start_latch;                                           // qualified trigger seen
  logic [glitch_cfg_pkg::OFFSET_WIDTH-1:0]     delay_cnt;
  logic [glitch_cfg_pkg::DONE_COUNT_WIDTH-1:0] count_pipe [glitch_cfg_pkg::SYNC_STAGES];
  logic [glitch_cfg_pkg::DONE_COUNT_WIDTH-1:0] count_sync;
  logic [glitch_cfg_pkg::DONE_COUNT_WIDTH-1:0] expected_count;  // num_glitches+1
  logic glitch_condition;
  logic count_reached;

  assign glitch_condition = (delay_cnt == offset);
  assign expected_count   = {1'b0, num_glitches} + 1'b1;
  assign count_sync       = count_pipe[glitch_cfg_pkg::SYNC_STAGES-1];
  assign count_reached    = (count_sync == expected_count) ||
                            (easy_done_exit && (num_glitches == '0));
  assign idle      = (state == glitch_fsm_pkg::RS_IDLE);
  assign fsm_state = state;

  // single mode needs the arm latch to qualify the trigger
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      start_latch <= 1'b0;
    end else if (trig_sync && (single_mode ? armed : 1'b1)) begin
      start_latch <= 1'b1;
    end else if (done) begin
      start_latch <= 1'b0;
    end
  end

  // count of finished pulses
  // treated as if the pulse gen ran on its own clock
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      for (int i = 0; i < glitch_cfg_pkg::SYNC_STAGES; i++) begin
        count_pipe[i] <= '0;
      end
    end else begin
      count_pipe[0] <= done_count;
      for (int i = 1; i < glitch_cfg_pkg::SYNC_STAGES; i++) begin
        count_pipe[i] <= count_pipe[i-1];
      end
    end
  end

  // delay counter restarts at 0 on every entry to WAIT
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      delay_cnt   <= '0;
      glitch_fire <= 1'b0;
    end else begin
      if (state == glitch_fsm_pkg::RS_WAIT) begin
        delay_cnt <= delay_cnt + 1'b1;
      end else begin
        delay_cnt <= '0;
      end
      glitch_fire <= (state == glitch_fsm_pkg::RS_WAIT) && glitch_condition;  // registered
    end
  end

  // glitch train sequencer
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      state <= glitch_fsm_pkg::RS_IDLE;
      done  <= 1'b0;
      index <= '0;
    end else begin
      done <= 1'b0;                      // one cycle pulse by default
      case (state)
        glitch_fsm_pkg::RS_IDLE: begin
          index <= '0;
          if (start_latch && !done) begin  // ignore the latch still set from last run
            state <= glitch_fsm_pkg::RS_WAIT;
          end
        end
        glitch_fsm_pkg::RS_WAIT: begin
          if (glitch_condition) begin
            index <= index + 1'b1;       // lines up with glitch_fire
            if (index < num_glitches) begin
              state <= glitch_fsm_pkg::RS_NEXT;
            end else begin
              state <= glitch_fsm_pkg::RS_DONE;
            end
          end
        end
        glitch_fsm_pkg::RS_NEXT: begin
          state <= glitch_fsm_pkg::RS_WAIT;
        end
        glitch_fsm_pkg::RS_DONE: begin
          // index must hold until the last pulse is really over
          if ((!trig_sync && count_reached) || fsm_abort) begin
            state <= glitch_fsm_pkg::RS_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= glitch_fsm_pkg::RS_IDLE;
      endcase
    end
  end

  // fire marks the WAIT exit and the index step in the same cycle
  a_fire_after_wait: assert property (
    @(posedge clk) disable iff (exttrig)
    glitch_fire |-> ($past(state) == glitch_fsm_pkg::RS_WAIT) &&
                    (state != glitch_fsm_pkg::RS_WAIT) &&
                    (index == $past(index) + 1'b1)
  ) else $error("glitch_fire out of step with the WAIT exit or the index");

  a_done_single: assert property (
    @(posedge clk) disable iff (exttrig)
    done |=> !done
  ) else $error("done high for two cycles");

endmodule

// File: trigger_arm.sv
`timescale 1ns/1ps

module trigger_arm (
  input  logic clk,
  input  logic exttrig,     // async reset, active high
  input  logic trig_in,     // raw trigger from the target
  input  logic arm,         // strobe, enables one run in single mode
  input  logic done,        // end of run from the resync FSM
  output logic trig_sync,
  output logic armed
);

  logic [glitch_cfg_pkg::SYNC_STAGES-1:0] trig_pipe;  // oldest sample in the top bit

  // plain flop chain, trig_in is asynchronous to clk
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      trig_pipe <= '0;
    end else begin
      trig_pipe <= {trig_pipe[glitch_cfg_pkg::SYNC_STAGES-2:0], trig_in};
    end
  end

  assign trig_sync = trig_pipe[glitch_cfg_pkg::SYNC_STAGES-1];

  // single-shot latch
  // done wins so a run always leaves the latch cleared
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      armed <= 1'b0;
    end else if (done) begin
      armed <= 1'b0;          // run finished, needs a fresh arm
    end else if (arm) begin
      armed <= 1'b1;
    end
  end

  // arm landing while the resync FSM reports done would lose the arm silently
  a_arm_not_at_done: assert property (
    @(posedge clk) disable iff (exttrig)
    $rose(armed) |-> !done
  ) else $error("armed rose in the same cycle as done");

endmodule

// File: glitch_fsm_pkg.sv
package glitch_fsm_pkg;

  // resync sequencer states, also seen on the top-level fsm_state port
  typedef enum logic [1:0] {
    RS_IDLE = 2'd0,   // waiting for a qualified trigger
    RS_WAIT = 2'd1,   // counting up to offset
    RS_NEXT = 2'd2,   // one cycle gap between glitches
    RS_DONE = 2'd3    // waiting for the last pulse and trigger release
  } resync_state_t;

  // pulse generator states
  typedef enum logic {
    PG_IDLE = 1'b0,
    PG_HIGH = 1'b1    // glitch_out asserted
  } pulse_state_t;

endpackage

// File: glitch_cfg_pkg.sv
package glitch_cfg_pkg;

  // glitch train size
  localparam int NUM_GLITCH_WIDTH = 5;   // num_glitches and index
  // one extra bit so the count can reach num_glitches+1
  localparam int DONE_COUNT_WIDTH = NUM_GLITCH_WIDTH + 1;

  // trigger to first glitch delay
  localparam int OFFSET_WIDTH = 32;      // offset and delay counter

  // glitch pulse length in clk cycles
  localparam int PULSE_WIDTH_BITS = 8;

  // flop depth of the trigger sync and of the done count pipe
  localparam int SYNC_STAGES = 2;

endpackage
